// File: hdl/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_mask_t;
    typedef logic [4:0]  reg_idx_t;

    // load widths, codes 3'b011, 3'b110 and 3'b111 are illegal
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    // store widths, everything above sw is illegal
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // one funct3 field, read as ld or st depending on the access kind
    typedef union packed {
        load_funct3_t  ld;
        store_funct3_t st;
    } mem_funct_u;

endpackage : rv32i_pkg

// File: hdl/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [1:0] {
        alu_out    = 2'b00,
        br_en_zext = 2'b01,
        u_imm      = 2'b10
    } exe_fwd_sel_t;

    typedef logic [63:0] order_t;

    // one issued instruction as it waits in the queue
    typedef struct packed {
        rv32i_pkg::word_t      alu_out;
        rv32i_pkg::word_t      rs2;
        rv32i_pkg::word_t      u_imm;
        logic                  br_en;
        exe_fwd_sel_t          fwd_sel;
        logic                  mem_read;
        logic                  mem_write;
        rv32i_pkg::mem_funct_u funct;
        rv32i_pkg::reg_idx_t   rd;
    } issue_entry_t;

    // exe-to-mem register contents
    typedef struct packed {
        rv32i_pkg::word_t      fwd_data;
        rv32i_pkg::word_t      addr;      // word aligned
        rv32i_pkg::byte_mask_t mask;      // rmask or wmask
        logic                  mem_read;
        logic                  mem_write;
        logic                  trap;
        rv32i_pkg::reg_idx_t   rd;
        order_t                order;
    } mem_entry_t;

endpackage : pipe_pkg

// File: hdl/dmem_if.sv
`timescale 1ns/1ps

interface dmem_if;

    logic                  req_valid;
    logic                  we;
    rv32i_pkg::word_t      addr;
    rv32i_pkg::byte_mask_t byte_en;
    rv32i_pkg::word_t      wdata;
    rv32i_pkg::word_t      rdata;

    modport master (
        output req_valid, we, addr, byte_en, wdata,
        input  rdata
    );

    modport slave (
        input  req_valid, we, addr, byte_en, wdata,
        output rdata
    );

endinterface : dmem_if

// File: hdl/issue_queue.sv
`timescale 1ns/1ps

module issue_queue #(
    parameter int ISSUE_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid_i,
    input  pipe_pkg::issue_entry_t issue_i,
    input  logic                   pop_i,
    output logic                   head_valid_o,
    output pipe_pkg::issue_entry_t head_o,
    output logic                   issue_credit_o
);

    localparam int PTR_W = (ISSUE_DEPTH > 1) ? $clog2(ISSUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(ISSUE_DEPTH + 1);

    pipe_pkg::issue_entry_t entries [ISSUE_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(ISSUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign head_valid_o   = (count != '0);
    assign head_o         = entries[rd_ptr];
    assign pop            = pop_i && head_valid_o;
    assign issue_credit_o = pop; // one credit back per entry leaving

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (issue_valid_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(issue_valid_i) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            entries[wr_ptr] <= issue_i;
        end
    end

    // producer must hold a credit, so a full queue never sees a push
    a_no_push_when_full : assert property (
        @(posedge clk) disable iff (rst)
        issue_valid_i |-> (count != CNT_W'(ISSUE_DEPTH))
    ) else $error("issue while queue full");

endmodule : issue_queue

// File: hdl/exe_mem_stage.sv
`timescale 1ns/1ps

module exe_mem_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   head_valid_i,
    input  pipe_pkg::issue_entry_t head_i,
    input  logic                   advance_i,
    output logic                   pop_o,
    output logic                   mem_valid_o,
    output pipe_pkg::mem_entry_t   mem_o,
    dmem_if.master                 dmem
);

    rv32i_pkg::word_t      fwd_val;
    rv32i_pkg::word_t      store_data;
    rv32i_pkg::word_t      wdata_q;
    rv32i_pkg::byte_mask_t mask;
    logic [1:0]            offset;
    logic                  trap;
    pipe_pkg::order_t      order_cnt;

    assign offset = head_i.alu_out[1:0];
    assign pop_o  = head_valid_i && (!mem_valid_o || advance_i); // reload as entry leaves

    always_comb begin : exe_fwd_mux
        case (head_i.fwd_sel)
            pipe_pkg::br_en_zext: fwd_val = {31'b0, head_i.br_en};
            pipe_pkg::u_imm:      fwd_val = head_i.u_imm;
            default:              fwd_val = head_i.alu_out;
        endcase
    end

    always_comb begin : lane_prep
        mask       = 4'b0000;
        trap       = 1'b0;
        store_data = head_i.rs2; // sw goes out unshifted
        if (head_i.mem_read) begin
            case (head_i.funct.ld)
                rv32i_pkg::lw:                 mask = 4'b1111 << offset;
                rv32i_pkg::lh, rv32i_pkg::lhu: mask = 4'b0011 << offset;
                rv32i_pkg::lb, rv32i_pkg::lbu: mask = 4'b0001 << offset;
                default:                       trap = 1'b1;
            endcase
        end else if (head_i.mem_write) begin
            case (head_i.funct.st)
                rv32i_pkg::sw: mask = 4'b1111 << offset;
                rv32i_pkg::sh: begin
                    mask       = 4'b0011 << offset;
                    store_data = head_i.rs2 << {offset, 3'b000};
                end
                rv32i_pkg::sb: begin
                    mask       = 4'b0001 << offset;
                    store_data = head_i.rs2 << {offset, 3'b000};
                end
                default: trap = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            mem_valid_o <= 1'b0;
            order_cnt   <= '1; // first pop wraps to 0
        end else if (pop_o) begin
            mem_valid_o <= 1'b1;
            order_cnt   <= order_cnt + 64'd1;
        end else if (advance_i) begin
            mem_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            mem_o.fwd_data  <= fwd_val;
            mem_o.addr      <= {head_i.alu_out[31:2], 2'b00};
            mem_o.mask      <= mask;
            mem_o.mem_read  <= head_i.mem_read;
            mem_o.mem_write <= head_i.mem_write;
            mem_o.trap      <= trap;
            mem_o.rd        <= head_i.rd;
            mem_o.order     <= order_cnt + 64'd1;
            wdata_q         <= store_data;
        end
    end

    // single access per entry, made in the cycle it is handed on
    assign dmem.req_valid = mem_valid_o && advance_i;
    assign dmem.we        = mem_valid_o && mem_o.mem_write && !mem_o.trap;
    assign dmem.addr      = mem_o.addr;
    assign dmem.byte_en   = mem_o.mask;
    assign dmem.wdata     = wdata_q;

    a_rw_exclusive : assert property (
        @(posedge clk) disable iff (rst)
        pop_o |-> !(head_i.mem_read && head_i.mem_write)
    ) else $error("entry is both load and store");

endmodule : exe_mem_stage

// File: hdl/dmem_bank.sv
`timescale 1ns/1ps

module dmem_bank #(
    parameter int DMEM_WORDS = 64
) (
    input logic   clk,
    input logic   rst,
    dmem_if.slave dmem
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    rv32i_pkg::word_t mem [DMEM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx        = dmem.addr[IDX_W+1:2]; // wraps modulo DMEM_WORDS
    assign dmem.rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (dmem.req_valid && dmem.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dmem.byte_en[lane]) begin
                    mem[idx][8*lane +: 8] <= dmem.wdata[8*lane +: 8];
                end
            end
        end
    end

    // a write with no lanes means the trap path leaked a store
    a_we_has_lanes : assert property (
        @(posedge clk) disable iff (rst)
        dmem.we |-> (dmem.byte_en != 4'b0000)
    ) else $error("write with empty byte enable");

endmodule : dmem_bank

// File: hdl/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage #(
    parameter int WB_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_valid_i,
    input  pipe_pkg::mem_entry_t  mem_i,
    input  rv32i_pkg::word_t      rdata_i,
    input  logic                  wb_credit_i,
    output logic                  advance_o,
    output logic                  wb_valid_o,
    output rv32i_pkg::word_t      wb_data_o,
    output rv32i_pkg::reg_idx_t   wb_rd_o,
    output pipe_pkg::order_t      wb_order_o,
    output rv32i_pkg::word_t      wb_addr_o,
    output rv32i_pkg::byte_mask_t wb_mask_o,
    output logic                  wb_trap_o
);

    localparam int CNT_W = $clog2(WB_CREDITS + 1);

    logic             full_q;
    logic             send;
    logic             load;
    logic [CNT_W-1:0] credit_cnt;
    rv32i_pkg::word_t result;

    assign send       = full_q && (credit_cnt != '0);
    assign advance_o  = !full_q || send;
    assign load       = mem_valid_i && advance_o;
    assign wb_valid_o = send;

    // trapped loads fall back to the forward value
    assign result = (mem_i.mem_read && !mem_i.trap) ? rdata_i : mem_i.fwd_data;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            full_q     <= 1'b0;
            credit_cnt <= CNT_W'(WB_CREDITS);
        end else begin
            if (load) begin
                full_q <= 1'b1;
            end else if (send) begin
                full_q <= 1'b0;
            end
            credit_cnt <= credit_cnt - CNT_W'(send) + CNT_W'(wb_credit_i);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wb_data_o  <= result;
            wb_rd_o    <= mem_i.rd;
            wb_order_o <= mem_i.order;
            wb_addr_o  <= mem_i.addr;
            wb_mask_o  <= mem_i.mask;
            wb_trap_o  <= mem_i.trap;
        end
    end

    // consumer returns no more credits than it was given
    a_credit_bound : assert property (
        @(posedge clk) disable iff (rst)
        credit_cnt <= CNT_W'(WB_CREDITS)
    ) else $error("credit counter above WB_CREDITS");

endmodule : mem_wb_stage

// File: hdl/lsu_pipe.sv
`timescale 1ns/1ps

module lsu_pipe #(
    parameter int ISSUE_DEPTH = 4,
    parameter int WB_CREDITS  = 2,
    parameter int DMEM_WORDS  = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid_i,
    input  rv32i_pkg::word_t       alu_out_i,
    input  rv32i_pkg::word_t       rs2_i,
    input  rv32i_pkg::word_t       u_imm_i,
    input  logic                   br_en_i,
    input  pipe_pkg::exe_fwd_sel_t fwd_sel_i,
    input  logic                   mem_read_i,
    input  logic                   mem_write_i,
    input  logic [2:0]             funct_i,
    input  rv32i_pkg::reg_idx_t    rd_i,
    input  logic                   wb_credit_i,
    output logic                   issue_credit_o,
    output logic                   wb_valid_o,
    output rv32i_pkg::word_t       wb_data_o,
    output rv32i_pkg::reg_idx_t    wb_rd_o,
    output pipe_pkg::order_t       wb_order_o,
    output rv32i_pkg::word_t       wb_addr_o,
    output rv32i_pkg::byte_mask_t  wb_mask_o,
    output logic                   wb_trap_o
);

    pipe_pkg::issue_entry_t issue_entry;
    pipe_pkg::issue_entry_t head;
    pipe_pkg::mem_entry_t   mem_entry;
    logic                   head_valid;
    logic                   pop;
    logic                   mem_valid;
    logic                   advance;

    dmem_if dmem_bus ();

    always_comb begin
        issue_entry.alu_out   = alu_out_i;
        issue_entry.rs2       = rs2_i;
        issue_entry.u_imm     = u_imm_i;
        issue_entry.br_en     = br_en_i;
        issue_entry.fwd_sel   = fwd_sel_i;
        issue_entry.mem_read  = mem_read_i;
        issue_entry.mem_write = mem_write_i;
        issue_entry.funct     = funct_i; // decoded per access kind downstream
        issue_entry.rd        = rd_i;
    end

    issue_queue #(
        .ISSUE_DEPTH (ISSUE_DEPTH)
    ) i_issue_queue (
        .clk            (clk),
        .rst            (rst),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_entry),
        .pop_i          (pop),
        .head_valid_o   (head_valid),
        .head_o         (head),
        .issue_credit_o (issue_credit_o)
    );

    exe_mem_stage i_exe_mem_stage (
        .clk          (clk),
        .rst          (rst),
        .head_valid_i (head_valid),
        .head_i       (head),
        .advance_i    (advance),
        .pop_o        (pop),
        .mem_valid_o  (mem_valid),
        .mem_o        (mem_entry),
        .dmem         (dmem_bus.master)
    );

    dmem_bank #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_dmem_bank (
        .clk  (clk),
        .rst  (rst),
        .dmem (dmem_bus.slave)
    );

    mem_wb_stage #(
        .WB_CREDITS (WB_CREDITS)
    ) i_mem_wb_stage (
        .clk         (clk),
        .rst         (rst),
        .mem_valid_i (mem_valid),
        .mem_i       (mem_entry),
        .rdata_i     (dmem_bus.rdata),
        .wb_credit_i (wb_credit_i),
        .advance_o   (advance),
        .wb_valid_o  (wb_valid_o),
        .wb_data_o   (wb_data_o),
        .wb_rd_o     (wb_rd_o),
        .wb_order_o  (wb_order_o),
        .wb_addr_o   (wb_addr_o),
        .wb_mask_o   (wb_mask_o),
        .wb_trap_o   (wb_trap_o)
    );

endmodule : lsu_pipe

// File: bench/lsu_pipe_tb.sv
`timescale 1ns/1ps

module lsu_pipe_tb;

    localparam int ISSUE_DEPTH  = 4;
    localparam int WB_CREDITS   = 2;
    localparam int DMEM_WORDS   = 64;
    localparam int REGION_WORDS = 8;
    localparam int N_RANDOM     = 40;
    localparam rv32i_pkg::word_t REGION = 32'h0000_1000; // wraps onto word 0

    typedef struct packed {
        rv32i_pkg::word_t      data;
        rv32i_pkg::word_t      addr;
        rv32i_pkg::byte_mask_t mask;
        logic                  trap;
        rv32i_pkg::reg_idx_t   rd;
        pipe_pkg::order_t      order;
    } expect_t;

    logic                   clk;
    logic                   rst;
    logic                   issue_valid;
    logic                   br_en;
    logic                   mem_read;
    logic                   mem_write;
    logic                   wb_credit;
    rv32i_pkg::word_t       alu_out;
    rv32i_pkg::word_t       rs2;
    rv32i_pkg::word_t       u_imm;
    pipe_pkg::exe_fwd_sel_t fwd_sel;
    logic [2:0]             funct;
    rv32i_pkg::reg_idx_t    rd;
    logic                   issue_credit;
    logic                   wb_valid;
    logic                   wb_trap;
    rv32i_pkg::word_t       wb_data;
    rv32i_pkg::word_t       wb_addr;
    rv32i_pkg::reg_idx_t    wb_rd;
    pipe_pkg::order_t       wb_order;
    rv32i_pkg::byte_mask_t  wb_mask;

    rv32i_pkg::word_t       mirror [DMEM_WORDS];
    pipe_pkg::issue_entry_t stim_q[$];
    pipe_pkg::issue_entry_t issued_q[$];
    int                     due_q[$];
    int                     seed;
    int                     credits;
    int                     outstanding;
    int                     cycle;
    int                     n_instr;
    int                     n_checked;

    lsu_pipe #(
        .ISSUE_DEPTH (ISSUE_DEPTH),
        .WB_CREDITS  (WB_CREDITS),
        .DMEM_WORDS  (DMEM_WORDS)
    ) i_lsu_pipe (
        .clk            (clk),
        .rst            (rst),
        .issue_valid_i  (issue_valid),
        .alu_out_i      (alu_out),
        .rs2_i          (rs2),
        .u_imm_i        (u_imm),
        .br_en_i        (br_en),
        .fwd_sel_i      (fwd_sel),
        .mem_read_i     (mem_read),
        .mem_write_i    (mem_write),
        .funct_i        (funct),
        .rd_i           (rd),
        .wb_credit_i    (wb_credit),
        .issue_credit_o (issue_credit),
        .wb_valid_o     (wb_valid),
        .wb_data_o      (wb_data),
        .wb_rd_o        (wb_rd),
        .wb_order_o     (wb_order),
        .wb_addr_o      (wb_addr),
        .wb_mask_o      (wb_mask),
        .wb_trap_o      (wb_trap)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic rv32i_pkg::word_t region_addr(input int off);
        return REGION + 32'(4 * rand_below(REGION_WORDS) + off);
    endfunction

    function automatic pipe_pkg::issue_entry_t make_instr(input logic ld, input logic st,
                                                          input logic [2:0] f3,
                                                          input rv32i_pkg::word_t addr);
        pipe_pkg::issue_entry_t e;
        e.alu_out   = addr;
        e.rs2       = 32'($random(seed));
        e.u_imm     = 32'($random(seed));
        e.br_en     = (rand_below(2) == 1);
        e.fwd_sel   = pipe_pkg::exe_fwd_sel_t'(rand_below(3));
        e.mem_read  = ld;
        e.mem_write = st;
        e.funct.ld  = rv32i_pkg::load_funct3_t'(f3);
        e.rd        = 5'(rand_below(32));
        return e;
    endfunction

    // expected result of the idx-th instruction, mirror memory updated for stores
    function automatic expect_t ref_result(input pipe_pkg::issue_entry_t e, input int idx);
        expect_t          x;
        logic [2:0]       f3;
        logic             legal;
        logic [3:0]       lanes;
        int               off;
        int               w;
        rv32i_pkg::word_t sdata;
        f3    = e.funct;
        off   = int'(e.alu_out[1:0]);
        w     = int'(e.alu_out[31:2]) % DMEM_WORDS;
        legal = e.mem_read ? !(f3 == 3'd3 || f3 >= 3'd6) : (f3 <= 3'd2);
        lanes = (f3[1:0] == 2'd0) ? 4'b0001 : (f3[1:0] == 2'd1) ? 4'b0011 : 4'b1111;
        case (e.fwd_sel)
            pipe_pkg::br_en_zext: x.data = 32'(e.br_en);
            pipe_pkg::u_imm:      x.data = e.u_imm;
            default:              x.data = e.alu_out;
        endcase
        x.addr  = e.alu_out & 32'hffff_fffc;
        x.trap  = (e.mem_read || e.mem_write) && !legal;
        x.mask  = ((e.mem_read || e.mem_write) && legal) ? (lanes << off) : 4'b0000;
        x.rd    = e.rd;
        x.order = 64'(idx);
        if (e.mem_read && legal) begin
            x.data = mirror[w]; // whole aligned word
        end
        if (e.mem_write && legal) begin
            sdata = (f3 == 3'd2) ? e.rs2 : e.rs2 << (8 * off);
            for (int b = 0; b < 4; b++) begin
                if (x.mask[b]) begin
                    mirror[w][8*b +: 8] = sdata[8*b +: 8];
                end
            end
        end
        return x;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "first mismatch");
    endtask

    task automatic check_word(input string what, input rv32i_pkg::word_t got, exp);
        if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_mask(input string what, input rv32i_pkg::byte_mask_t got, exp);
        if (got !== exp) report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_order(input string what, input pipe_pkg::order_t got, exp);
        if (got !== exp) report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_flag(input string what, input rv32i_pkg::reg_idx_t got, exp);
        if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic build_program();
        pipe_pkg::issue_entry_t e;
        rv32i_pkg::word_t       a;
        int                     kind;
        for (int i = 0; i < REGION_WORDS; i++) begin
            stim_q.push_back(make_instr(1'b0, 1'b1, 3'd2, REGION + 32'(4 * i)));
        end
        for (int k = 0; k < 9; k++) begin
            e         = make_instr(1'b0, 1'b0, 3'(rand_below(8)), 32'($random(seed)));
            e.fwd_sel = pipe_pkg::exe_fwd_sel_t'(k % 3);
            stim_q.push_back(e);
        end
        // every funct3 at every offset, each store read back as a word
        for (int f = 0; f < 8; f++) begin
            for (int off = 0; off < 4; off++) begin
                stim_q.push_back(make_instr(1'b1, 1'b0, 3'(f), region_addr(off)));
                a = region_addr(off);
                stim_q.push_back(make_instr(1'b0, 1'b1, 3'(f), a));
                stim_q.push_back(make_instr(1'b1, 1'b0, 3'd2, a & 32'hffff_fffc));
            end
        end
        for (int k = 0; k < N_RANDOM; k++) begin
            kind = rand_below(3);
            stim_q.push_back(make_instr(kind == 1, kind == 2, 3'(rand_below(8)),
                                        region_addr(rand_below(4))));
        end
    endtask

    task automatic run_producer();
        pipe_pkg::issue_entry_t e;
        while (stim_q.size() > 0) begin
            @(posedge clk);
            #1;
            issue_valid = 1'b0;
            if (credits > 0 && rand_below(4) != 0) begin
                e           = stim_q.pop_front();
                issue_valid = 1'b1;
                alu_out     = e.alu_out;
                rs2         = e.rs2;
                u_imm       = e.u_imm;
                br_en       = e.br_en;
                fwd_sel     = e.fwd_sel;
                mem_read    = e.mem_read;
                mem_write   = e.mem_write;
                funct       = e.funct;
                rd          = e.rd;
                issued_q.push_back(e);
                credits--;
            end
        end
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    always @(negedge clk) begin : count_issue_credits
        if (!rst && issue_credit) begin
            credits++;
        end
    end

    always @(negedge clk) begin : consume
        if (!rst && wb_valid) begin
            outstanding++;
            due_q.push_back(cycle + rand_below(4)); // hand back 0 to 3 cycles later
            if (outstanding > WB_CREDITS) begin
                $display("more results outstanding than the %0d credits given", WB_CREDITS);
                $display("Checks failed");
                $fatal(1, "credit overrun");
            end
        end
    end

    initial begin : return_credits
        int pick;
        forever begin
            @(posedge clk);
            #1;
            cycle++;
            pick = -1;
            foreach (due_q[i]) begin
                if (pick < 0 && due_q[i] < cycle) begin
                    pick = i;
                end
            end
            wb_credit = (pick >= 0); // one credit per cycle at most
            if (pick >= 0) begin
                due_q.delete(pick);
                outstanding--;
            end
        end
    end

    always @(negedge clk) begin : compare
        pipe_pkg::issue_entry_t e;
        expect_t                x;
        if (!rst && wb_valid) begin
            if (issued_q.size() == 0) begin
                $display("a result came out with no instruction in flight");
                $display("Checks failed");
                $fatal(1, "unexpected result");
            end else begin
                e = issued_q.pop_front();
                x = ref_result(e, n_checked);
                check_word($sformatf("result %0d data", n_checked), wb_data, x.data);
                check_word($sformatf("result %0d addr", n_checked), wb_addr, x.addr);
                check_mask($sformatf("result %0d mask", n_checked), wb_mask, x.mask);
                check_order($sformatf("result %0d order", n_checked), wb_order, x.order);
                check_flag($sformatf("result %0d trap", n_checked), {4'b0, wb_trap},
                           {4'b0, x.trap});
                check_flag($sformatf("result %0d rd", n_checked), wb_rd, x.rd);
                n_checked++;
            end
        end
    end

    initial begin : watchdog
        wait (n_instr > 0);
        repeat (20 * n_instr) @(posedge clk);
        $display("timeout, the pipeline stopped producing results after %0d of %0d",
                 n_checked, n_instr);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        seed        = 32'hc26712f2;
        rst         = 1'b1;
        issue_valid = 1'b0;
        alu_out     = '0;
        rs2         = '0;
        u_imm       = '0;
        br_en       = 1'b0;
        fwd_sel     = pipe_pkg::alu_out;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        funct       = 3'd0;
        rd          = '0;
        wb_credit   = 1'b0;
        credits     = ISSUE_DEPTH;
        outstanding = 0;
        n_checked   = 0;
        build_program();
        n_instr = stim_q.size();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        run_producer();
        wait (n_checked == n_instr);
        repeat (8) @(posedge clk); // catch any extra result
        // every pop hands one credit back, so the producer ends where it began
        if (credits == ISSUE_DEPTH) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("FAILED at %0t: producer holds %0d credits expected %0d",
                     $time, credits, ISSUE_DEPTH);
            $display("Checks failed");
            $fatal(1, "issue credits lost or duplicated");
        end
    end

endmodule : lsu_pipe_tb

// File: lsu_pipe.f
hdl/rv32i_pkg.sv
hdl/pipe_pkg.sv
hdl/dmem_if.sv
hdl/issue_queue.sv
hdl/exe_mem_stage.sv
hdl/dmem_bank.sv
hdl/mem_wb_stage.sv
hdl/lsu_pipe.sv
bench/lsu_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the lsu_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f lsu_pipe.f --top-module lsu_pipe_tb \
    --Mdir obj_dir -o lsu_pipe_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/lsu_pipe_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
echo "simulation passed"
exit 0
